// File: lc3_isa_pkg.sv
package lc3_isa_pkg;

    // --------------------------------------------------
    // data and field types
    // --------------------------------------------------
    typedef logic [15:0] word_t;        // data word and address
    typedef logic [2:0]  reg_idx_t;     // r0..r7
    typedef logic [2:0]  nzp_t;         // ordered n, z, p

    // only the opcodes this core executes
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    localparam word_t reset_pc = 16'h3000;  // user program origin

    // --------------------------------------------------
    // instruction field positions
    // --------------------------------------------------
    localparam int dr_msb       = 11;   // dr, also sr for st/str and nzp for br
    localparam int sr1_msb      = 8;    // sr1, also baser
    localparam int imm_flag_bit = 5;    // 1 selects imm5 on add/and

    // offset field widths, all sign extended
    localparam int imm5_w  = 5;
    localparam int off6_w  = 6;
    localparam int off9_w  = 9;
    localparam int off11_w = 11;

endpackage

// File: lc3_ctrl_pkg.sv
package lc3_ctrl_pkg;

    // --------------------------------------------------
    // controller states
    // --------------------------------------------------
    typedef enum logic [3:0] {
        s_fetch_mar,    // mar <- pc, pc <- pc + 1
        s_fetch_wait,   // instruction read in flight
        s_fetch_ir,     // ir <- mdr
        s_decode,
        s_alu,          // add, and, not
        s_lea,
        s_br,
        s_jmp,
        s_ld_mar,       // ld, ldr address
        s_ld_wait,
        s_ld_dr,
        s_st_mar,       // st, str address
        s_st_mdr,       // mdr <- sr
        s_st_wait,
        s_halt          // trap ends here
    } ctrl_state_t;

    // --------------------------------------------------
    // datapath selects
    // --------------------------------------------------
    typedef enum logic [2:0] {src_none, src_pc, src_mdr, src_alu, src_marmux} bus_src_t;

    typedef enum logic [1:0] {pc_inc, pc_bus, pc_ea} pc_sel_t;

    typedef enum logic {a1_pc, a1_sr1} addr1_sel_t;

    typedef enum logic [1:0] {a2_zero, a2_off6, a2_off9, a2_off11} addr2_sel_t;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} alu_op_t;

    // register index taken from ir[11:9] or ir[8:6]
    typedef enum logic {dr_11_9, dr_8_6} dr_sel_t;
    typedef enum logic {sr1_11_9, sr1_8_6} sr1_sel_t;

endpackage

// File: lc3_regfile.sv
module lc3_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  lc3_isa_pkg::word_t     ir,
    input  lc3_ctrl_pkg::dr_sel_t  dr_sel,
    input  lc3_ctrl_pkg::sr1_sel_t sr1_sel,
    input  logic                   ld_reg,
    input  lc3_isa_pkg::word_t     bus,
    output lc3_isa_pkg::word_t     sr1,
    output lc3_isa_pkg::word_t     sr2
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t    regs [8];
    reg_idx_t dr_idx;
    reg_idx_t sr1_idx;
    reg_idx_t sr2_idx;

    assign dr_idx  = (dr_sel == dr_11_9) ? ir[dr_msb -: 3] : ir[sr1_msb -: 3];
    assign sr1_idx = (sr1_sel == sr1_11_9) ? ir[dr_msb -: 3] : ir[sr1_msb -: 3];
    assign sr2_idx = ir[2:0];

    assign sr1 = regs[sr1_idx];     // both reads combinational
    assign sr2 = regs[sr2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ld_reg) begin
            regs[dr_idx] <= bus;
        end
    end

endmodule

// File: lc3_alu.sv
module lc3_alu (
    input  lc3_isa_pkg::word_t    ir,
    input  lc3_isa_pkg::word_t    sr1,
    input  lc3_isa_pkg::word_t    sr2,
    input  lc3_ctrl_pkg::alu_op_t alu_op,
    output lc3_isa_pkg::word_t    result
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t imm5;
    word_t operand_b;

    assign imm5      = {{(16 - imm5_w){ir[imm5_w-1]}}, ir[imm5_w-1:0]};
    assign operand_b = ir[imm_flag_bit] ? imm5 : sr2;

    always_comb begin
        case (alu_op)
            alu_add: result = sr1 + operand_b;
            alu_and: result = sr1 & operand_b;
            alu_not: result = ~sr1;
            default: result = sr1;      // pass, used by st/str and jmp
        endcase
    end

endmodule

// File: lc3_pc_addr.sv
module lc3_pc_addr (
    input  logic                     clk,
    input  logic                     rst,
    input  lc3_isa_pkg::word_t       ir,
    input  lc3_isa_pkg::word_t       sr1,
    input  lc3_isa_pkg::word_t       bus,
    input  lc3_ctrl_pkg::pc_sel_t    pc_sel,
    input  lc3_ctrl_pkg::addr1_sel_t addr1_sel,
    input  lc3_ctrl_pkg::addr2_sel_t addr2_sel,
    input  logic                     ld_pc,
    output lc3_isa_pkg::word_t       pc,
    output lc3_isa_pkg::word_t       ea,
    output lc3_isa_pkg::word_t       marmux
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t addr1;
    word_t addr2;
    word_t pc_nxt;

    // --------------------------------------------------
    // effective address adder
    // --------------------------------------------------
    assign addr1 = (addr1_sel == a1_sr1) ? sr1 : pc;

    always_comb begin
        case (addr2_sel)
            a2_off6:  addr2 = {{(16 - off6_w){ir[off6_w-1]}}, ir[off6_w-1:0]};
            a2_off9:  addr2 = {{(16 - off9_w){ir[off9_w-1]}}, ir[off9_w-1:0]};
            a2_off11: addr2 = {{(16 - off11_w){ir[off11_w-1]}}, ir[off11_w-1:0]};
            default:  addr2 = '0;
        endcase
    end

    assign ea     = addr1 + addr2;
    assign marmux = ea;         // no trap vector path, trap only halts

    // --------------------------------------------------
    // program counter
    // --------------------------------------------------
    always_comb begin
        case (pc_sel)
            pc_bus:  pc_nxt = bus;
            pc_ea:   pc_nxt = ea;
            default: pc_nxt = pc + 16'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ld_pc) begin
            pc <= pc_nxt;
        end
    end

endmodule

// File: lc3_mem_if.sv
module lc3_mem_if (
    input  logic               clk,
    input  logic               rst,
    input  lc3_isa_pkg::word_t bus,
    input  logic               ld_mar,
    input  logic               ld_mdr,
    input  logic               mem_req,
    input  logic               mem_write,
    output lc3_isa_pkg::word_t mdr,
    output logic               mem_done,
    output logic               mem_en,
    output logic               mem_we,
    output lc3_isa_pkg::word_t mem_addr,
    output lc3_isa_pkg::word_t mem_wdata,
    input  lc3_isa_pkg::word_t mem_rdata,
    input  logic               mem_ready
);
    import lc3_isa_pkg::*;

    word_t mar;

    assign mem_done  = mem_en & mem_ready;  // access ends on this edge
    assign mem_addr  = mar;
    assign mem_wdata = mdr;

    always_ff @(posedge clk) begin
        if (ld_mar) begin
            mar <= bus;
        end
        if (ld_mdr) begin
            mdr <= bus;
        end else if (mem_done && !mem_we) begin
            mdr <= mem_rdata;               // read data capture
        end
    end

    // one request outstanding, held until ready
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_en <= 1'b0;
            mem_we <= 1'b0;
        end else if (mem_done) begin
            mem_en <= 1'b0;
        end else if (mem_req && !mem_en) begin
            mem_en <= 1'b1;
            mem_we <= mem_write;
        end
    end

endmodule

// File: lc3_datapath.sv
module lc3_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ld_mar,
    input  logic                     ld_mdr,
    input  logic                     ld_ir,
    input  logic                     ld_reg,
    input  logic                     ld_cc,
    input  logic                     ld_pc,
    input  lc3_ctrl_pkg::bus_src_t   bus_src,
    input  lc3_ctrl_pkg::pc_sel_t    pc_sel,
    input  lc3_ctrl_pkg::addr1_sel_t addr1_sel,
    input  lc3_ctrl_pkg::addr2_sel_t addr2_sel,
    input  lc3_ctrl_pkg::alu_op_t    alu_op,
    input  lc3_ctrl_pkg::dr_sel_t    dr_sel,
    input  lc3_ctrl_pkg::sr1_sel_t   sr1_sel,
    input  logic                     mem_req,
    input  logic                     mem_write,
    output lc3_isa_pkg::word_t       ir,
    output lc3_isa_pkg::nzp_t        nzp,
    output logic                     mem_done,
    output logic                     mem_en,
    output logic                     mem_we,
    output lc3_isa_pkg::word_t       mem_addr,
    output lc3_isa_pkg::word_t       mem_wdata,
    input  lc3_isa_pkg::word_t       mem_rdata,
    input  logic                     mem_ready
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t bus;
    word_t sr1;
    word_t sr2;
    word_t alu_result;
    word_t pc;
    word_t marmux;
    word_t mdr;

    // --------------------------------------------------
    // internal bus, one driver at a time
    // --------------------------------------------------
    always_comb begin
        case (bus_src)
            src_pc:     bus = pc;
            src_mdr:    bus = mdr;
            src_alu:    bus = alu_result;
            src_marmux: bus = marmux;
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir  <= '0;
            nzp <= 3'b010;      // z after reset
        end else begin
            if (ld_ir) begin
                ir <= bus;
            end
            if (ld_cc) begin
                nzp <= {bus[15], bus == '0, !bus[15] && bus != '0};
            end
        end
    end

    lc3_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .ir      (ir),
        .dr_sel  (dr_sel),
        .sr1_sel (sr1_sel),
        .ld_reg  (ld_reg),
        .bus     (bus),
        .sr1     (sr1),
        .sr2     (sr2)
    );

    lc3_alu u_alu (
        .ir     (ir),
        .sr1    (sr1),
        .sr2    (sr2),
        .alu_op (alu_op),
        .result (alu_result)
    );

    lc3_pc_addr u_pc_addr (
        .clk       (clk),
        .rst       (rst),
        .ir        (ir),
        .sr1       (sr1),
        .bus       (bus),
        .pc_sel    (pc_sel),
        .addr1_sel (addr1_sel),
        .addr2_sel (addr2_sel),
        .ld_pc     (ld_pc),
        .pc        (pc),
        .ea        (),
        .marmux    (marmux)
    );

    lc3_mem_if u_mem_if (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .ld_mar    (ld_mar),
        .ld_mdr    (ld_mdr),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mdr       (mdr),
        .mem_done  (mem_done),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

// File: lc3_ctrl.sv
module lc3_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  lc3_isa_pkg::word_t       ir,
    input  lc3_isa_pkg::nzp_t        nzp,
    input  logic                     mem_done,
    output logic                     ld_mar,
    output logic                     ld_mdr,
    output logic                     ld_ir,
    output logic                     ld_reg,
    output logic                     ld_cc,
    output logic                     ld_pc,
    output lc3_ctrl_pkg::bus_src_t   bus_src,
    output lc3_ctrl_pkg::pc_sel_t    pc_sel,
    output lc3_ctrl_pkg::addr1_sel_t addr1_sel,
    output lc3_ctrl_pkg::addr2_sel_t addr2_sel,
    output lc3_ctrl_pkg::alu_op_t    alu_op,
    output lc3_ctrl_pkg::dr_sel_t    dr_sel,
    output lc3_ctrl_pkg::sr1_sel_t   sr1_sel,
    output logic                     mem_req,
    output logic                     mem_write,
    output logic                     halted
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    opcode_t     opcode;
    logic        br_taken;
    logic        base_offset;   // ldr/str addressing

    assign opcode      = opcode_t'(ir[15:12]);
    assign br_taken    = |(ir[dr_msb -: 3] & nzp);
    assign base_offset = (opcode == op_ldr) || (opcode == op_str);
    assign halted      = (state == s_halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch_mar;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------
    // next state and control decode
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        ld_mar    = 1'b0;
        ld_mdr    = 1'b0;
        ld_ir     = 1'b0;
        ld_reg    = 1'b0;
        ld_cc     = 1'b0;
        ld_pc     = 1'b0;
        bus_src   = src_none;
        pc_sel    = pc_inc;
        addr1_sel = a1_pc;
        addr2_sel = a2_zero;
        alu_op    = alu_pass;
        dr_sel    = dr_11_9;
        sr1_sel   = sr1_8_6;
        mem_req   = 1'b0;
        mem_write = 1'b0;
        case (state)
            s_fetch_mar: begin
                bus_src   = src_pc;
                ld_mar    = 1'b1;
                ld_pc     = 1'b1;          // pc_inc by default
                state_nxt = s_fetch_wait;
            end
            s_fetch_wait: begin
                mem_req = 1'b1;
                if (mem_done) begin
                    state_nxt = s_fetch_ir;
                end
            end
            s_fetch_ir: begin
                bus_src   = src_mdr;
                ld_ir     = 1'b1;
                state_nxt = s_decode;
            end
            s_decode: begin
                case (opcode)
                    op_add, op_and, op_not: state_nxt = s_alu;
                    op_lea:                 state_nxt = s_lea;
                    op_br:                  state_nxt = s_br;
                    op_jmp:                 state_nxt = s_jmp;
                    op_ld, op_ldr:          state_nxt = s_ld_mar;
                    op_st, op_str:          state_nxt = s_st_mar;
                    op_trap:                state_nxt = s_halt;
                    default:                state_nxt = s_fetch_mar;  // unsupported, skipped
                endcase
            end
            s_alu: begin
                case (opcode)
                    op_and:  alu_op = alu_and;
                    op_not:  alu_op = alu_not;
                    default: alu_op = alu_add;
                endcase
                bus_src   = src_alu;
                ld_reg    = 1'b1;
                ld_cc     = 1'b1;
                state_nxt = s_fetch_mar;
            end
            s_lea: begin
                addr2_sel = a2_off9;       // cc untouched
                bus_src   = src_marmux;
                ld_reg    = 1'b1;
                state_nxt = s_fetch_mar;
            end
            s_br: begin
                addr2_sel = a2_off9;
                pc_sel    = pc_ea;
                ld_pc     = br_taken;
                state_nxt = s_fetch_mar;
            end
            s_jmp: begin
                bus_src   = src_alu;       // baser passed through the alu
                pc_sel    = pc_bus;
                ld_pc     = 1'b1;
                state_nxt = s_fetch_mar;
            end
            s_ld_mar, s_st_mar: begin
                if (base_offset) begin
                    addr1_sel = a1_sr1;
                    addr2_sel = a2_off6;
                end else begin
                    addr2_sel = a2_off9;
                end
                bus_src   = src_marmux;
                ld_mar    = 1'b1;
                state_nxt = (state == s_ld_mar) ? s_ld_wait : s_st_mdr;
            end
            s_ld_wait: begin
                mem_req = 1'b1;
                if (mem_done) begin
                    state_nxt = s_ld_dr;
                end
            end
            s_ld_dr: begin
                bus_src   = src_mdr;
                ld_reg    = 1'b1;
                ld_cc     = 1'b1;
                state_nxt = s_fetch_mar;
            end
            s_st_mdr: begin
                sr1_sel   = sr1_11_9;      // store source register
                bus_src   = src_alu;
                ld_mdr    = 1'b1;
                state_nxt = s_st_wait;
            end
            s_st_wait: begin
                mem_req   = 1'b1;
                mem_write = 1'b1;
                if (mem_done) begin
                    state_nxt = s_fetch_mar;
                end
            end
            default: state_nxt = s_halt;   // s_halt holds until reset
        endcase
    end

endmodule

// File: lc3_top.sv
module lc3_top (
    input  logic               clk,
    input  logic               rst,
    output logic               mem_en,
    output logic               mem_we,
    output lc3_isa_pkg::word_t mem_addr,
    output lc3_isa_pkg::word_t mem_wdata,
    input  lc3_isa_pkg::word_t mem_rdata,
    input  logic               mem_ready,
    output logic               halted
);

    // --------------------------------------------------
    // controller to datapath
    // --------------------------------------------------
    logic                     ld_mar;
    logic                     ld_mdr;
    logic                     ld_ir;
    logic                     ld_reg;
    logic                     ld_cc;
    logic                     ld_pc;
    lc3_ctrl_pkg::bus_src_t   bus_src;
    lc3_ctrl_pkg::pc_sel_t    pc_sel;
    lc3_ctrl_pkg::addr1_sel_t addr1_sel;
    lc3_ctrl_pkg::addr2_sel_t addr2_sel;
    lc3_ctrl_pkg::alu_op_t    alu_op;
    lc3_ctrl_pkg::dr_sel_t    dr_sel;
    lc3_ctrl_pkg::sr1_sel_t   sr1_sel;
    logic                     mem_req;
    logic                     mem_write;
    lc3_isa_pkg::word_t       ir;           // back to the controller
    lc3_isa_pkg::nzp_t        nzp;
    logic                     mem_done;

    lc3_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ir        (ir),
        .nzp       (nzp),
        .mem_done  (mem_done),
        .ld_mar    (ld_mar),
        .ld_mdr    (ld_mdr),
        .ld_ir     (ld_ir),
        .ld_reg    (ld_reg),
        .ld_cc     (ld_cc),
        .ld_pc     (ld_pc),
        .bus_src   (bus_src),
        .pc_sel    (pc_sel),
        .addr1_sel (addr1_sel),
        .addr2_sel (addr2_sel),
        .alu_op    (alu_op),
        .dr_sel    (dr_sel),
        .sr1_sel   (sr1_sel),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .halted    (halted)
    );

    lc3_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .ld_mar    (ld_mar),
        .ld_mdr    (ld_mdr),
        .ld_ir     (ld_ir),
        .ld_reg    (ld_reg),
        .ld_cc     (ld_cc),
        .ld_pc     (ld_pc),
        .bus_src   (bus_src),
        .pc_sel    (pc_sel),
        .addr1_sel (addr1_sel),
        .addr2_sel (addr2_sel),
        .alu_op    (alu_op),
        .dr_sel    (dr_sel),
        .sr1_sel   (sr1_sel),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .ir        (ir),
        .nzp       (nzp),
        .mem_done  (mem_done),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

// File: tb_lc3_mem.sv
module tb_lc3_mem (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_en,
    input  logic               mem_we,
    input  lc3_isa_pkg::word_t mem_addr,
    input  lc3_isa_pkg::word_t mem_wdata,
    output lc3_isa_pkg::word_t mem_rdata,
    output logic               mem_ready,
    output logic               busy,        // request seen, not yet ended
    output lc3_isa_pkg::word_t req_addr,
    output logic               req_we,
    output lc3_isa_pkg::word_t req_wdata,
    output logic               wr_valid,    // one cycle per finished store
    output lc3_isa_pkg::word_t wr_addr,
    output lc3_isa_pkg::word_t wr_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import lc3_isa_pkg::*;

    // --------------------------------------------------
    // test program at reset_pc, four words per line
    // --------------------------------------------------
    localparam word_t prog [32] = '{
        16'h0401, 16'h3043, 16'h1227, 16'h147D,    // brz +1, skipped st r0, add r1, add r2
        16'h1642, 16'h58C1, 16'h5AFE, 16'h9CFF,    // add reg, and reg, and imm, not
        16'h3637, 16'h3837, 16'h3A37, 16'h3C37,    // st r3..r6 to x3040..x3043
        16'h3437, 16'h22F2, 16'hEEF1, 16'h65C1,    // st r2, ld r1, lea r7, ldr r2
        16'h73D0, 16'h75D1, 16'h7FD2, 16'h1629,    // str r1, r2, r7 to x3110.., add r3 #9
        16'h0801, 16'h3630, 16'h0201, 16'h302F,    // brn not taken, st r3, brp +1, skipped st
        16'h183F, 16'h382E, 16'hEA03, 16'hC140,    // add r4 #-1, st r4, lea r5, jmp r5
        16'h302C, 16'h302B, 16'h3A2B, 16'hF025     // two skipped st, st r5, trap
    };

    word_t  mem [65536];
    integer seed;
    int     delay;      // ready wait cycles left

    initial begin
        seed      = 89563;
        mem_rdata = '0;
        mem_ready = 1'b0;
        busy      = 1'b0;
        req_addr  = '0;
        req_we    = 1'b0;
        req_wdata = '0;
        wr_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        delay     = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[word_t'(a)] = word_t'(a) ^ 16'hC3A5;
        end
        for (int i = 0; i < 32; i++) begin
            mem[reset_pc + word_t'(i)] = prog[5'(i)];
        end
        mem[16'h3100] = 16'h1234;   // ld source
        mem[16'h3101] = 16'hBEEF;   // ldr source
        forever begin
            @(posedge clk);
            #1;
            wr_valid = 1'b0;
            if (rst) begin
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (mem_ready) begin
                // access ended on the edge just passed
                if (req_we) begin
                    mem[req_addr] = req_wdata;
                    wr_valid      = 1'b1;
                    wr_addr       = req_addr;
                    wr_data       = req_wdata;
                end
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (mem_en && !busy) begin
                busy      = 1'b1;
                req_addr  = mem_addr;
                req_we    = mem_we;
                req_wdata = mem_wdata;
                delay     = $unsigned($random(seed)) % 4;   // 0 to 3 cycles
            end
            if (busy && !mem_ready) begin
                if (delay == 0) begin
                    mem_ready = 1'b1;
                    if (!req_we) begin
                        mem_rdata = mem[req_addr];
                    end
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

// File: tb_lc3.sv
module tb_lc3;
    timeunit 1ns;
    timeprecision 100ps;
    import lc3_isa_pkg::*;

    localparam logic [3:0] n_stores     = 4'd11;
    localparam int         halt_timeout = 4000;    // cycles
    localparam int         quiet_cycles = 50;

    logic       clk;
    logic       rst;
    logic       mem_en;
    logic       mem_we;
    word_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;
    logic       mem_ready;
    logic       halted;
    logic       busy;
    word_t      req_addr;
    logic       req_we;
    word_t      req_wdata;
    logic       wr_valid;
    word_t      wr_addr;
    word_t      wr_data;
    logic [3:0] store_idx;      // next expected store
    word_t      exp_addr [n_stores];
    word_t      exp_data [n_stores];

    lc3_top lc3_top_i (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted)
    );

    tb_lc3_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .busy      (busy),
        .req_addr  (req_addr),
        .req_we    (req_we),
        .req_wdata (req_wdata),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            store_idx <= '0;
        end else if (wr_valid) begin
            store_idx <= store_idx + 4'd1;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // bus checks
    // --------------------------------------------------
    assert property (@(posedge clk) (rst && $past(rst)) |-> !mem_en)
        else report_failure($sformatf("Mismatch at %0t ns: mem_en expected 0, got %b",
                                      $time, mem_en));
    assert property (@(posedge clk) (rst && $past(rst)) |-> !halted)
        else report_failure($sformatf("Mismatch at %0t ns: halted expected 0, got %b",
                                      $time, halted));

    // request held until the ready edge
    assert property (@(posedge clk) busy |-> mem_en)
        else report_failure($sformatf("Mismatch at %0t ns: mem_en expected 1, got %b",
                                      $time, mem_en));
    assert property (@(posedge clk) busy |-> mem_addr == req_addr)
        else report_failure($sformatf("Mismatch at %0t ns: mem_addr expected %h, got %h",
                                      $time, req_addr, mem_addr));
    assert property (@(posedge clk) busy |-> mem_we == req_we)
        else report_failure($sformatf("Mismatch at %0t ns: mem_we expected %b, got %b",
                                      $time, req_we, mem_we));
    assert property (@(posedge clk) busy |-> mem_wdata == req_wdata)
        else report_failure($sformatf("Mismatch at %0t ns: mem_wdata expected %h, got %h",
                                      $time, req_wdata, mem_wdata));

    // --------------------------------------------------
    // store checks, in program order
    // --------------------------------------------------
    assert property (@(posedge clk) wr_valid |-> store_idx < n_stores)
        else report_failure($sformatf("unexpected extra store of %h to %h at %0t ns",
                                      wr_data, wr_addr, $time));
    assert property (@(posedge clk)
                     (wr_valid && store_idx < n_stores) |-> wr_addr == exp_addr[store_idx])
        else report_failure($sformatf("Mismatch at %0t ns: mem_addr expected %h, got %h",
                                      $time, exp_addr[store_idx], wr_addr));
    assert property (@(posedge clk)
                     (wr_valid && store_idx < n_stores) |-> wr_data == exp_data[store_idx])
        else report_failure($sformatf("Mismatch at %0t ns: mem_wdata expected %h, got %h",
                                      $time, exp_data[store_idx], wr_data));

    initial begin
        int n;
        rst = 1'b1;
        // alu results, loads and lea, br markers, jmp marker
        exp_addr = '{16'h3040, 16'h3041, 16'h3042, 16'h3043, 16'h3044, 16'h3110,
                     16'h3111, 16'h3112, 16'h3046, 16'h3048, 16'h304A};
        exp_data = '{16'h000B, 16'h0003, 16'h000A, 16'hFFF4, 16'h0004, 16'h1234,
                     16'hBEEF, 16'h3100, 16'h0009, 16'hFFFF, 16'h301E};
        repeat (16) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;

        n = 0;
        while (!mem_en) begin
            if (n == 2) begin
                report_failure("no fetch request within 2 cycles after reset");
            end else begin
                @(posedge clk);
                #1;
                n = n + 1;
            end
        end
        assert (mem_addr == reset_pc)
            else report_failure($sformatf("Mismatch at %0t ns: mem_addr expected %h, got %h",
                                          $time, reset_pc, mem_addr));
        assert (!mem_we)
            else report_failure($sformatf("Mismatch at %0t ns: mem_we expected 0, got %b",
                                          $time, mem_we));

        n = 0;
        while (!halted) begin
            if (n == halt_timeout) begin
                report_failure("timeout waiting for halted after the trap");
            end else begin
                @(posedge clk);
                #1;
                n = n + 1;
            end
        end

        repeat (quiet_cycles) begin     // core must stay idle
            @(posedge clk);
            #1;
            assert (!mem_en)
                else report_failure($sformatf("Mismatch at %0t ns: mem_en expected 0, got %b",
                                              $time, mem_en));
            assert (halted)
                else report_failure($sformatf("Mismatch at %0t ns: halted expected 1, got %b",
                                              $time, halted));
        end

        if (store_idx == n_stores) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure($sformatf("only %0d of %0d expected stores seen",
                                     store_idx, n_stores));
        end
    end

endmodule

// File: lc3.f
lc3_isa_pkg.sv
lc3_ctrl_pkg.sv
lc3_regfile.sv
lc3_alu.sv
lc3_pc_addr.sv
lc3_mem_if.sv
lc3_datapath.sv
lc3_ctrl.sv
lc3_top.sv
tb_lc3_mem.sv
tb_lc3.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lc3 testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_lc3 -Mdir obj_dir -o Vtb_lc3 -f lc3.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lc3 > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TB FAILED" "$log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
